// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f tb.f --top-module tb_riscv_decode -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir

// File: rtl/alu_op_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// funct3/funct7 to ALU operation
// Combinational; MULDIV funct7 is illegal
// Illegal encodings give ALU_DC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_op_decode (
    input  decode_pkg::alu_class_t            alu_class,
    input  logic [decode_pkg::FUNCT3_W-1:0]   funct3,
    input  logic [decode_pkg::FUNCT7_W-1:0]   funct7,
    output decode_pkg::alu_op_t               alu_op,
    output logic                              alu_illegal
);

    logic f7_int;
    logic f7_alt;
    logic is_reg;

    assign f7_int = (funct7 == decode_pkg::FUNCT7_INT);
    assign f7_alt = (funct7 == decode_pkg::FUNCT7_ALT_INT);
    assign is_reg = (alu_class == decode_pkg::ALU_CLASS_REG);

    always_comb begin
        alu_op      = decode_pkg::ALU_DC;
        alu_illegal = 1'b0;

        if (alu_class == decode_pkg::ALU_CLASS_FIXED_ADD) begin
            alu_op = decode_pkg::ALU_ADD;
        end else if (is_reg || alu_class == decode_pkg::ALU_CLASS_IMM) begin
            unique case (funct3)
                decode_pkg::FUNCT3_ADD_SUB: begin
                    // Immediate form has no SUB
                    if (!is_reg || f7_int)
                        alu_op = decode_pkg::ALU_ADD;
                    else if (f7_alt)
                        alu_op = decode_pkg::ALU_SUB;
                    else
                        alu_illegal = 1'b1;
                end
                decode_pkg::FUNCT3_SRL_SRA: begin
                    // Both forms carry the shift type in funct7
                    if (f7_int)
                        alu_op = decode_pkg::ALU_SRL;
                    else if (f7_alt)
                        alu_op = decode_pkg::ALU_SRA;
                    else
                        alu_illegal = 1'b1;
                end
                default: begin
                    unique case (funct3)
                        decode_pkg::FUNCT3_SLL:  alu_op = decode_pkg::ALU_SLL;
                        decode_pkg::FUNCT3_SLT:  alu_op = decode_pkg::ALU_SLT;
                        decode_pkg::FUNCT3_SLTU: alu_op = decode_pkg::ALU_SLTU;
                        decode_pkg::FUNCT3_XOR:  alu_op = decode_pkg::ALU_XOR;
                        decode_pkg::FUNCT3_OR:   alu_op = decode_pkg::ALU_OR;
                        decode_pkg::FUNCT3_AND:  alu_op = decode_pkg::ALU_AND;
                        default:                 alu_op = decode_pkg::ALU_DC;
                    endcase
                    // Register form only allows funct7 zero here
                    if (is_reg && !f7_int) begin
                        alu_op      = decode_pkg::ALU_DC;
                        alu_illegal = 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/decode_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode control and registered output word
// One word per pop, only while execute credits remain
// Execute side must not return more than OUT_CREDITS
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module decode_ctrl #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [decode_pkg::ILEN-1:0] head,
    input  logic                        not_empty,
    output logic                        pop,
    output logic                        instr_credit,
    output decode_pkg::alu_class_t      alu_class,
    output decode_pkg::mem_kind_t       mem_kind,
    input  decode_pkg::alu_op_t         alu_op_dec,
    input  logic                        alu_illegal,
    input  decode_pkg::ldst_mode_t      ldst_mode_dec,
    input  logic                        ldst_illegal,
    input  logic                        ctrl_credit,
    output logic                        ctrl_valid,
    output logic                        rf_write,
    output logic                        mem_to_rf,
    output logic                        pc_to_rf,
    output logic                        ui_to_rf,
    output logic                        aui_to_rf,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        use_imm,
    output logic                        use_rs1,
    output logic                        use_rs2,
    output logic                        syscall,
    output logic                        illegal_instr,
    output decode_pkg::imm_mode_t       imm_mode,
    output decode_pkg::alu_op_t         alu_op,
    output decode_pkg::ldst_mode_t      ldst_mode
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    decode_pkg::opcode_t   opcode;
    logic [2:0]            funct3;
    logic                  rs1_n0;
    logic                  rs2_n0;
    logic [CW-1:0]         credits;
    logic                  op_illegal;
    logic                  no_alu;
    logic [10:0]           flags;
    decode_pkg::imm_mode_t imm_sel;

    assign opcode = decode_pkg::opcode_t'(head[6:0]);
    assign funct3 = head[14:12];
    assign rs1_n0 = (head[19:15] != '0);
    assign rs2_n0 = (head[24:20] != '0);

    assign pop          = not_empty && (credits != '0);
    assign instr_credit = pop;

    // flags: rf_write, mem_to_rf, pc_to_rf, ui_to_rf, aui_to_rf, mem_read,
    // mem_write, use_imm, use_rs1, use_rs2, syscall
    always_comb begin
        flags      = '0;
        imm_sel    = decode_pkg::IMM_I;
        alu_class  = decode_pkg::ALU_CLASS_FIXED_ADD;
        mem_kind   = decode_pkg::MEM_NONE;
        op_illegal = 1'b0;
        no_alu     = 1'b0;
        unique case (opcode)
            decode_pkg::OP: begin
                flags     = {1'b1, 7'b0, rs1_n0, rs2_n0, 1'b0};
                alu_class = decode_pkg::ALU_CLASS_REG;
            end
            decode_pkg::OP_IMM: begin
                flags     = {1'b1, 6'b0, 1'b1, rs1_n0, 2'b0};
                alu_class = decode_pkg::ALU_CLASS_IMM;
            end
            decode_pkg::LOAD: begin
                flags    = {2'b11, 3'b0, 1'b1, 1'b0, 1'b1, rs1_n0, 2'b0};
                mem_kind = decode_pkg::MEM_LOAD;
            end
            decode_pkg::STORE: begin
                flags    = {6'b0, 2'b11, rs1_n0, rs2_n0, 1'b0};
                imm_sel  = decode_pkg::IMM_S;
                mem_kind = decode_pkg::MEM_STORE;
            end
            decode_pkg::LUI: begin
                flags   = {1'b1, 2'b0, 1'b1, 3'b0, 1'b1, 3'b0};
                imm_sel = decode_pkg::IMM_U;
            end
            decode_pkg::AUIPC: begin
                flags   = {1'b1, 3'b0, 1'b1, 2'b0, 1'b1, 3'b0};
                imm_sel = decode_pkg::IMM_U;
            end
            decode_pkg::JAL: begin
                flags   = {1'b1, 1'b0, 1'b1, 4'b0, 1'b1, 3'b0};
                imm_sel = decode_pkg::IMM_UJ;
            end
            decode_pkg::JALR: begin
                flags      = {1'b1, 1'b0, 1'b1, 4'b0, 1'b1, rs1_n0, 2'b0};
                op_illegal = (funct3 != decode_pkg::FUNCT3_JALR);
            end
            decode_pkg::BRANCH: begin
                // Branch condition is resolved downstream; 2 and 3 are unused
                flags      = {7'b0, 1'b1, rs1_n0, rs2_n0, 1'b0};
                imm_sel    = decode_pkg::IMM_SB;
                op_illegal = (funct3[2:1] == 2'b01);
            end
            decode_pkg::SYSTEM: begin
                if (head[31:20] == decode_pkg::FUNCT12_ECALL) begin
                    flags = {8'b0, rs1_n0, 1'b0, 1'b1};
                end else begin
                    op_illegal = 1'b1;
                    no_alu     = 1'b1;
                end
            end
            default: begin
                op_illegal = 1'b1;
                no_alu     = 1'b1;
            end
        endcase
    end

    // Credits and valid
    always_ff @(posedge clk) begin
        if (reset) begin
            credits       <= CW'(OUT_CREDITS);
            ctrl_valid    <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            credits    <= credits + CW'(ctrl_credit) - CW'(pop);
            ctrl_valid <= pop;
            if (pop)
                illegal_instr <= op_illegal | alu_illegal | ldst_illegal;
        end
    end

    // Payload of the control word
    always_ff @(posedge clk) begin
        if (pop) begin
            {rf_write, mem_to_rf, pc_to_rf, ui_to_rf, aui_to_rf, mem_read,
             mem_write, use_imm, use_rs1, use_rs2, syscall} <= flags;
            imm_mode  <= imm_sel;
            alu_op    <= no_alu ? decode_pkg::ALU_DC : alu_op_dec;
            ldst_mode <= ldst_mode_dec;
        end
    end

    assert property (@(posedge clk) disable iff (reset) credits <= CW'(OUT_CREDITS))
        else $error("execute side returned more credits than it was given");

endmodule

// File: rtl/decode_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared RV32I decode definitions
// Base integer ISA only; funct7 0x01 (MULDIV) is not recognized
// LDST encodings follow the load funct3 values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package decode_pkg;

    // Instruction field widths
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'h33,
        OP_IMM = 7'h13,
        LOAD   = 7'h03,
        STORE  = 7'h23,
        LUI    = 7'h37,
        AUIPC  = 7'h17,
        JAL    = 7'h6f,
        JALR   = 7'h67,
        BRANCH = 7'h63,
        SYSTEM = 7'h73
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_DC   = 4'hf
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I  = 3'd0,
        IMM_S  = 3'd1,
        IMM_SB = 3'd2,
        IMM_U  = 3'd3,
        IMM_UJ = 3'd4
    } imm_mode_t;

    // Same values as the load funct3 field
    typedef enum logic [2:0] {
        LDST_B  = 3'd0,
        LDST_H  = 3'd1,
        LDST_W  = 3'd2,
        LDST_BU = 3'd4,
        LDST_HU = 3'd5,
        LDST_DC = 3'd7
    } ldst_mode_t;

    // How funct3/funct7 are interpreted for the ALU
    typedef enum logic [1:0] {
        ALU_CLASS_REG       = 2'd0,
        ALU_CLASS_IMM       = 2'd1,
        ALU_CLASS_FIXED_ADD = 2'd2
    } alu_class_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_kind_t;

    localparam logic [FUNCT7_W-1:0] FUNCT7_INT     = 7'h00;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT_INT = 7'h20;
    localparam logic [11:0]         FUNCT12_ECALL  = 12'h000;

    // Integer funct3 codes
    localparam logic [FUNCT3_W-1:0] FUNCT3_ADD_SUB = 3'd0;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SLL     = 3'd1;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SLT     = 3'd2;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SLTU    = 3'd3;
    localparam logic [FUNCT3_W-1:0] FUNCT3_XOR     = 3'd4;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SRL_SRA = 3'd5;
    localparam logic [FUNCT3_W-1:0] FUNCT3_OR      = 3'd6;
    localparam logic [FUNCT3_W-1:0] FUNCT3_AND     = 3'd7;

    // JALR only defines funct3 zero
    localparam logic [FUNCT3_W-1:0] FUNCT3_JALR = 3'd0;

endpackage

// File: rtl/instr_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction FIFO on the fetch side
// Sender must honor credits; no full/empty backpressure
// Head is valid only while not_empty is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module instr_buffer #(
    parameter int INSTR_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  logic [decode_pkg::ILEN-1:0] instr,
    input  logic                        pop,
    output logic [decode_pkg::ILEN-1:0] head,
    output logic                        not_empty
);

    localparam int PW = (INSTR_DEPTH > 1) ? $clog2(INSTR_DEPTH) : 1;
    localparam int CW = $clog2(INSTR_DEPTH + 1);

    logic [decode_pkg::ILEN-1:0] slots [INSTR_DEPTH];
    logic [PW-1:0]               wr_ptr;
    logic [PW-1:0]               rd_ptr;
    logic [CW-1:0]               count;

    // Wrap at the last slot, depth need not be a power of two
    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        return (ptr == PW'(INSTR_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (instr_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            count <= count + CW'(instr_valid) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid)
            slots[wr_ptr] <= instr;
    end

    assign head      = slots[rd_ptr];
    assign not_empty = (count != '0);

    // Fetch side overran its credits
    assert property (@(posedge clk) disable iff (reset)
        !(instr_valid && count == CW'(INSTR_DEPTH)))
        else $error("instr_buffer write while full");

    assert property (@(posedge clk) disable iff (reset) !(pop && !not_empty))
        else $error("instr_buffer pop while empty");

endmodule

// File: rtl/mem_op_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// funct3 to load/store width
// Combinational; MEM_NONE is never illegal
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mem_op_decode (
    input  decode_pkg::mem_kind_t           mem_kind,
    input  logic [decode_pkg::FUNCT3_W-1:0] funct3,
    output decode_pkg::ldst_mode_t          ldst_mode,
    output logic                            ldst_illegal
);

    always_comb begin
        ldst_mode    = decode_pkg::LDST_DC;
        ldst_illegal = 1'b0;

        unique case (mem_kind)
            decode_pkg::MEM_LOAD: begin
                unique case (funct3)
                    3'd0:    ldst_mode = decode_pkg::LDST_B;
                    3'd1:    ldst_mode = decode_pkg::LDST_H;
                    3'd2:    ldst_mode = decode_pkg::LDST_W;
                    3'd4:    ldst_mode = decode_pkg::LDST_BU;
                    3'd5:    ldst_mode = decode_pkg::LDST_HU;
                    default: ldst_illegal = 1'b1;
                endcase
            end
            decode_pkg::MEM_STORE: begin
                // No unsigned stores
                unique case (funct3)
                    3'd0:    ldst_mode = decode_pkg::LDST_B;
                    3'd1:    ldst_mode = decode_pkg::LDST_H;
                    3'd2:    ldst_mode = decode_pkg::LDST_W;
                    default: ldst_illegal = 1'b1;
                endcase
            end
            default: ldst_mode = decode_pkg::LDST_DC;
        endcase
    end

endmodule

// File: rtl/riscv_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decoder, credit flow on both sides
// Fetch starts with INSTR_DEPTH credits, execute with OUT_CREDITS
// Minimum latency two cycles from instr_valid to ctrl_valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module riscv_decode #(
    parameter int INSTR_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  logic [decode_pkg::ILEN-1:0] instr,
    output logic                        instr_credit,
    input  logic                        ctrl_credit,
    output logic                        ctrl_valid,
    output logic                        rf_write,
    output logic                        mem_to_rf,
    output logic                        pc_to_rf,
    output logic                        ui_to_rf,
    output logic                        aui_to_rf,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        use_imm,
    output logic                        use_rs1,
    output logic                        use_rs2,
    output logic                        syscall,
    output logic                        illegal_instr,
    output decode_pkg::imm_mode_t       imm_mode,
    output decode_pkg::alu_op_t         alu_op,
    output decode_pkg::ldst_mode_t      ldst_mode
);

    logic [decode_pkg::ILEN-1:0] head;
    logic                        not_empty;
    logic                        pop;
    decode_pkg::alu_class_t      alu_class;
    decode_pkg::mem_kind_t       mem_kind;
    decode_pkg::alu_op_t         alu_op_dec;
    logic                        alu_illegal;
    decode_pkg::ldst_mode_t      ldst_mode_dec;
    logic                        ldst_illegal;

    instr_buffer #(.INSTR_DEPTH(INSTR_DEPTH)) u_instr_buffer (
        .clk, .reset, .instr_valid, .instr, .pop, .head, .not_empty
    );

    // Field decoders see the buffer head directly
    alu_op_decode u_alu_op_decode (
        .alu_class   (alu_class),
        .funct3      (head[14:12]),
        .funct7      (head[31:25]),
        .alu_op      (alu_op_dec),
        .alu_illegal (alu_illegal)
    );

    mem_op_decode u_mem_op_decode (
        .mem_kind     (mem_kind),
        .funct3       (head[14:12]),
        .ldst_mode    (ldst_mode_dec),
        .ldst_illegal (ldst_illegal)
    );

    decode_ctrl #(.OUT_CREDITS(OUT_CREDITS)) u_decode_ctrl (
        .clk, .reset, .head, .not_empty, .pop, .instr_credit,
        .alu_class, .mem_kind, .alu_op_dec, .alu_illegal,
        .ldst_mode_dec, .ldst_illegal, .ctrl_credit, .ctrl_valid,
        .rf_write, .mem_to_rf, .pc_to_rf, .ui_to_rf, .aui_to_rf,
        .mem_read, .mem_write, .use_imm, .use_rs1, .use_rs2, .syscall,
        .illegal_instr, .imm_mode, .alu_op, .ldst_mode
    );

endmodule

// File: tb.f
rtl/decode_pkg.sv
rtl/instr_buffer.sv
rtl/alu_op_decode.sv
rtl/mem_op_decode.sv
rtl/decode_ctrl.sv
rtl/riscv_decode.sv
verification/tb_riscv_decode.sv

// File: verification/decode_trace.txt
// instr  expected: flags[23:12] rf_write..syscall,illegal_instr | imm_mode | alu_op | ldst_mode
// Illegal lines only compare illegal_instr; expected ffffffff ends the trace
003100b3 80c007 // add x1, x2, x3
403100b3 80c017 // sub
003110b3 80c027 // sll
003120b3 80c037 // slt
003130b3 80c047 // sltu
003140b3 80c057 // xor
003150b3 80c067 // srl
403150b3 80c077 // sra
003160b3 80c087 // or
003170b3 80c097 // and
003000b3 804007 // add x1, x0, x3
000100b3 808007 // add x1, x2, x0
023100b3 001000 // mul, MULDIV funct7
403140b3 001000 // xor with funct7 0x20
fff10093 818007 // addi x1, x2, -1
00513093 818047 // sltiu x1, x2, 5
00514093 818057 // xori x1, x2, 5
00311093 818027 // slli x1, x2, 3
00315093 818067 // srli x1, x2, 3
40315093 818077 // srai x1, x2, 3
00700093 810007 // addi x1, x0, 7
20315093 001000 // srli with funct7 0x10
00410083 c58000 // lb x1, 4(x2)
00411083 c58001 // lh
00412083 c58002 // lw
00414083 c58004 // lbu
00415083 c58005 // lhu
00413083 001000 // load width 3
00310423 03c100 // sb x3, 8(x2)
00311423 03c101 // sh
00312423 03c102 // sw
00012423 038102 // sw x0, 8(x2)
00314423 001000 // store width 4
123450b7 910307 // lui x1, 0x12345
00001097 890307 // auipc x1, 0x1
008000ef a10407 // jal x1, 8
000100e7 a18007 // jalr x1, 0(x2)
000000e7 a10007 // jalr x1, 0(x0)
000110e7 001000 // jalr with funct3 1
00310463 01c207 // beq x2, x3, 8
00311463 01c207 // bne x2, x3, 8
00000463 010207 // beq x0, x0, 8
00312463 001000 // branch funct3 2
00000073 002007 // ecall
00100073 001000 // ebreak
00000000 001000 // opcode 0x00
ffffffff 001000 // opcode 0x7f
ffffffff ffffffff // end of trace

// File: verification/tb_riscv_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for riscv_decode
// Reads verification/decode_trace.txt, run from the project root
// Send and credit-return timing from a 32-bit LFSR with a fixed seed
// Payload fields of illegal instructions are not compared
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_riscv_decode;

    localparam int INSTR_DEPTH  = 4;
    localparam int OUT_CREDITS  = 2;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_ENTRIES  = 64;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        ctrl_credit;
    logic        instr_credit;
    logic        ctrl_valid;
    logic        rf_write, mem_to_rf, pc_to_rf, ui_to_rf, aui_to_rf;
    logic        mem_read, mem_write, use_imm, use_rs1, use_rs2, syscall;
    logic        illegal_instr;
    decode_pkg::imm_mode_t  imm_mode;
    decode_pkg::alu_op_t    alu_op;
    decode_pkg::ldst_mode_t ldst_mode;

    // Even words hold instructions, odd words the expected fields
    logic [31:0] trace_mem [2*MAX_ENTRIES];
    logic [31:0] instr_q [$];
    logic [23:0] exp_q [$];
    logic [31:0] lfsr = 32'h69ed;
    int trace_len = 0;
    int sent = 0;
    int checked = 0;
    int owed = 0;
    int credit_pulses = 0;
    int fetch_credits = INSTR_DEPTH;
    int exec_credits = OUT_CREDITS;
    int pending_return = 0;
    int credit_seen = 0;

    string flag_names [11] = '{"rf_write", "mem_to_rf", "pc_to_rf", "ui_to_rf",
        "aui_to_rf", "mem_read", "mem_write", "use_imm", "use_rs1", "use_rs2", "syscall"};

    riscv_decode #(.INSTR_DEPTH(INSTR_DEPTH), .OUT_CREDITS(OUT_CREDITS)) UUT (
        .clk, .reset, .instr_valid, .instr, .instr_credit, .ctrl_credit, .ctrl_valid,
        .rf_write, .mem_to_rf, .pc_to_rf, .ui_to_rf, .aui_to_rf, .mem_read,
        .mem_write, .use_imm, .use_rs1, .use_rs2, .syscall, .illegal_instr,
        .imm_mode, .alu_op, .ldst_mode
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] word,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h (instr %08h)",
                     $time, name, got, exp, word);
            abort_run("output value mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    task automatic check_idle(input string phase);
        check_value({"ctrl_valid ", phase}, 32'h0, 32'(ctrl_valid), 32'h0);
        check_value({"instr_credit ", phase}, 32'h0, 32'(instr_credit), 32'h0);
        check_value({"illegal_instr ", phase}, 32'h0, 32'(illegal_instr), 32'h0);
    endtask

    // Expected word packs flags[23:12], imm_mode[11:8], alu_op[7:4] and ldst_mode[3:0]
    task automatic check_word(input logic [31:0] word, input logic [23:0] exp);
        logic [10:0] got_flags;
        int i;
        got_flags = {rf_write, mem_to_rf, pc_to_rf, ui_to_rf, aui_to_rf, mem_read,
                     mem_write, use_imm, use_rs1, use_rs2, syscall};
        check_value("illegal_instr", word, 32'(illegal_instr), 32'(exp[12]));
        if (!exp[12]) begin
            for (i = 0; i < 11; i++)
                check_value(flag_names[i], word, 32'(got_flags[10-i]), 32'(exp[23-i]));
            check_value("imm_mode", word, 32'(imm_mode), 32'(exp[11:8]));
            check_value("alu_op", word, 32'(alu_op), 32'(exp[7:4]));
            check_value("ldst_mode", word, 32'(ldst_mode), 32'(exp[3:0]));
        end
    endtask

    task automatic observe_outputs();
        if (ctrl_valid) begin
            assert (exec_credits > 0)
                else abort_run("ctrl_valid rose with no execute credit left");
            assert (exp_q.size() > 0)
                else abort_run("ctrl_valid with no instruction outstanding");
            check_word(instr_q.pop_front(), exp_q.pop_front());
            exec_credits--;
            owed++;
            checked++;
        end
        // Credit driven last cycle was sampled at this rising edge
        exec_credits += pending_return;
        credit_seen = int'(instr_credit);
        credit_pulses += credit_seen;
    endtask

    task automatic drive_inputs();
        logic b0;
        logic b1;
        logic give;
        draw_bit(b0);
        draw_bit(b1);
        draw_bit(give);
        if ((b0 || b1) && fetch_credits > 0 && sent < trace_len) begin
            instr_valid = 1'b1;
            instr = trace_mem[2*sent];
            instr_q.push_back(trace_mem[2*sent]);
            exp_q.push_back(trace_mem[2*sent+1][23:0]);
            fetch_credits--;
            sent++;
        end else begin
            instr_valid = 1'b0;
            instr = '0;
        end
        ctrl_credit = give && owed > 0;
        if (ctrl_credit)
            owed--;
        pending_return = int'(ctrl_credit);
        // A returned fetch credit is usable from the next cycle on
        fetch_credits += credit_seen;
    endtask

    initial begin
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        ctrl_credit = 1'b0;
        $readmemh("verification/decode_trace.txt", trace_mem);
        while (trace_len < MAX_ENTRIES && trace_mem[2*trace_len+1] !== 32'hffff_ffff)
            trace_len++;
        assert (trace_len > 0 && trace_len < MAX_ENTRIES)
            else abort_run("trace file is empty or lacks its end marker");

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle("during reset");
        end
        reset = 1'b0;
        @(negedge clk);
        check_idle("after reset");

        while (checked < trace_len) begin
            observe_outputs();
            drive_inputs();
            @(negedge clk);
        end

        check_value("ctrl_valid after last word", 32'h0, 32'(ctrl_valid), 32'h0);
        check_value("instr_credit pulse count", 32'h0, 32'(credit_pulses), 32'(sent));
        $display("all tests passed");
        $finish;
    end

    // Watchdog armed when reset is released
    initial begin
        @(negedge reset);
        #(trace_len * 20 * CLK_PERIOD);
        $display("timeout with %0d of %0d words checked", checked, trace_len);
        abort_run("watchdog expired before all control words arrived");
    end

endmodule
